// ==== power2round_pkg.sv ====
package power2round_pkg;

    // ----------------------------------------------------------------------
    // ML-DSA constants, reduced polynomial size
    // ----------------------------------------------------------------------
    localparam int unsigned MLDSA_K = 2;
    localparam int unsigned MLDSA_N = 32;
    localparam int unsigned MLDSA_Q = 8380417;
    localparam int unsigned MLDSA_D = 13;

    localparam int unsigned COEFF_W    = 24;
    localparam int unsigned MEM_ADDR_W = 14;
    // Two coefficients per memory port
    localparam int unsigned MEM_DATA_W = 2 * COEFF_W;

    localparam int unsigned T1_W      = 10;
    localparam int unsigned SK_WORD_W = 64;
    // Eight t1 values per public-key write
    localparam int unsigned PK_WORD_W = 8 * T1_W;
    localparam int unsigned PK_ADDR_W = 8;

    // Each read pair returns four coefficients
    localparam int unsigned NUM_READS     = MLDSA_K * MLDSA_N / 4;
    localparam int unsigned NUM_SK_WRITES = MLDSA_K * MLDSA_N * MLDSA_D / SK_WORD_W;
    localparam int unsigned NUM_PK_WRITES = MLDSA_K * MLDSA_N * T1_W / PK_WORD_W;

    // Read pacer, 8 reads in every 13 cycles
    localparam logic [12:0] RD_PACE_INIT = 13'b0101101011011;

    // ----------------------------------------------------------------------
    // Memory request
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_cmd_e;

    typedef struct packed {
        rw_cmd_e                 rd_wr_en;
        logic [MEM_ADDR_W-1:0]   addr;
    } mem_req_t;

    // ----------------------------------------------------------------------
    // Coefficient groups and output words
    // ----------------------------------------------------------------------
    // coeff[0] is the lowest coefficient and sits in the low bits
    typedef struct packed {
        logic [3:0][MLDSA_D-1:0] coeff;
    } t0_group_t;

    typedef struct packed {
        logic [3:0][T1_W-1:0] coeff;
    } t1_group_t;

    typedef struct packed {
        logic [SK_WORD_W/2-1:0] hi;
        logic [SK_WORD_W/2-1:0] lo;
    } sk_word_t;

    typedef logic [PK_WORD_W-1:0] pk_word_t;

    // ----------------------------------------------------------------------
    // Controller states
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        T_RD_IDLE,
        T_RD_MEM,
        T_RD_DONE
    } rd_state_e;

    typedef enum logic [1:0] {
        SK_WR_IDLE,
        SK_WR_WAIT,
        SK_WR_MEM,
        SK_WR_DONE
    } sk_state_e;

    typedef enum logic [1:0] {
        PK_WR_IDLE,
        PK_WR_API,
        PK_WR_DONE
    } pk_state_e;

endpackage

// ==== power2round_ctrl.sv ====
module power2round_ctrl (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    zeroize,
    input  logic                                    enable,
    input  logic [power2round_pkg::MEM_ADDR_W-1:0]  src_base_addr,
    input  logic [power2round_pkg::MEM_ADDR_W-1:0]  sk_base_addr,
    input  logic                                    sk_buff_valid,
    input  logic                                    r_valid,
    output power2round_pkg::mem_req_t               mem_a_rd_req,
    output power2round_pkg::mem_req_t               mem_b_rd_req,
    output power2round_pkg::mem_req_t               skmem_a_wr_req,
    output power2round_pkg::mem_req_t               skmem_b_wr_req,
    output logic                                    rd_valid,
    output logic                                    pk_wren,
    output logic [power2round_pkg::PK_ADDR_W-1:0]   pk_wr_addr,
    output logic                                    done
);

    power2round_pkg::rd_state_e rd_state, rd_state_nxt;
    power2round_pkg::sk_state_e sk_state, sk_state_nxt;
    power2round_pkg::pk_state_e pk_state, pk_state_nxt;

    logic [power2round_pkg::MEM_ADDR_W-1:0] rd_addr;
    logic [power2round_pkg::MEM_ADDR_W-1:0] sk_addr;
    logic [power2round_pkg::PK_ADDR_W-1:0]  pk_addr;
    logic [12:0]                            rd_pace;

    logic rd_stb, sk_wr_stb;
    logic last_rd, last_sk, last_pk;

    // Reads step by 2, one pair per strobe
    assign rd_stb  = (rd_state == power2round_pkg::T_RD_MEM) & rd_pace[0];
    assign last_rd = rd_addr == src_base_addr
                   + power2round_pkg::MEM_ADDR_W'(2 * (power2round_pkg::NUM_READS - 1));

    assign sk_wr_stb = (sk_state == power2round_pkg::SK_WR_MEM) & sk_buff_valid;
    assign last_sk   = sk_addr == sk_base_addr
                     + power2round_pkg::MEM_ADDR_W'(2 * (power2round_pkg::NUM_SK_WRITES - 1));

    assign pk_wren = (pk_state == power2round_pkg::PK_WR_API) & r_valid;
    assign last_pk = pk_addr == power2round_pkg::PK_ADDR_W'(power2round_pkg::NUM_PK_WRITES - 1);

    // ----------------------------------------------------------------------
    // State, counters and pacer
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= power2round_pkg::T_RD_IDLE;
            sk_state <= power2round_pkg::SK_WR_IDLE;
            pk_state <= power2round_pkg::PK_WR_IDLE;
            rd_addr  <= '0;
            sk_addr  <= '0;
            pk_addr  <= '0;
            rd_pace  <= power2round_pkg::RD_PACE_INIT;
            done     <= 1'b0;
        end else if (zeroize) begin
            rd_state <= power2round_pkg::T_RD_IDLE;
            sk_state <= power2round_pkg::SK_WR_IDLE;
            pk_state <= power2round_pkg::PK_WR_IDLE;
            rd_addr  <= '0;
            sk_addr  <= '0;
            pk_addr  <= '0;
            rd_pace  <= power2round_pkg::RD_PACE_INIT;
            done     <= 1'b0;
        end else begin
            rd_state <= rd_state_nxt;
            sk_state <= sk_state_nxt;
            pk_state <= pk_state_nxt;

            // Counters reload in idle and hold at their last address
            if (rd_state == power2round_pkg::T_RD_IDLE)
                rd_addr <= src_base_addr;
            else if (rd_stb & ~last_rd)
                rd_addr <= rd_addr + power2round_pkg::MEM_ADDR_W'(2);

            if (sk_state == power2round_pkg::SK_WR_IDLE)
                sk_addr <= sk_base_addr;
            else if (sk_wr_stb & ~last_sk)
                sk_addr <= sk_addr + power2round_pkg::MEM_ADDR_W'(2);

            if (pk_state == power2round_pkg::PK_WR_IDLE)
                pk_addr <= '0;
            else if (pk_wren & ~last_pk)
                pk_addr <= pk_addr + power2round_pkg::PK_ADDR_W'(1);

            // Pacer rotates only while reading, restarts for every run
            if (rd_state == power2round_pkg::T_RD_MEM)
                rd_pace <= {rd_pace[0], rd_pace[12:1]};
            else
                rd_pace <= power2round_pkg::RD_PACE_INIT;

            done <= (sk_state == power2round_pkg::SK_WR_DONE);
        end
    end

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            power2round_pkg::T_RD_IDLE:
                if (enable) rd_state_nxt = power2round_pkg::T_RD_MEM;
            power2round_pkg::T_RD_MEM:
                if (rd_stb & last_rd) rd_state_nxt = power2round_pkg::T_RD_DONE;
            default:
                rd_state_nxt = power2round_pkg::T_RD_IDLE;
        endcase
    end

    always_comb begin
        sk_state_nxt = sk_state;
        case (sk_state)
            power2round_pkg::SK_WR_IDLE:
                if (rd_state != power2round_pkg::T_RD_IDLE)
                    sk_state_nxt = power2round_pkg::SK_WR_WAIT;
            power2round_pkg::SK_WR_WAIT:
                sk_state_nxt = power2round_pkg::SK_WR_MEM;
            power2round_pkg::SK_WR_MEM:
                if (sk_wr_stb & last_sk) sk_state_nxt = power2round_pkg::SK_WR_DONE;
            default:
                sk_state_nxt = power2round_pkg::SK_WR_IDLE;
        endcase
    end

    always_comb begin
        pk_state_nxt = pk_state;
        case (pk_state)
            power2round_pkg::PK_WR_IDLE:
                if (rd_state != power2round_pkg::T_RD_IDLE)
                    pk_state_nxt = power2round_pkg::PK_WR_API;
            power2round_pkg::PK_WR_API:
                if (pk_wren & last_pk) pk_state_nxt = power2round_pkg::PK_WR_DONE;
            default:
                pk_state_nxt = power2round_pkg::PK_WR_IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // Requests
    // ----------------------------------------------------------------------
    always_comb begin
        mem_a_rd_req.rd_wr_en = rd_stb ? power2round_pkg::RW_READ : power2round_pkg::RW_IDLE;
        mem_a_rd_req.addr     = {rd_addr[power2round_pkg::MEM_ADDR_W-1:1], 1'b0};
        mem_b_rd_req.rd_wr_en = rd_stb ? power2round_pkg::RW_READ : power2round_pkg::RW_IDLE;
        mem_b_rd_req.addr     = {rd_addr[power2round_pkg::MEM_ADDR_W-1:1], 1'b1};

        skmem_a_wr_req.rd_wr_en = sk_wr_stb ? power2round_pkg::RW_WRITE
                                            : power2round_pkg::RW_IDLE;
        skmem_a_wr_req.addr     = {sk_addr[power2round_pkg::MEM_ADDR_W-1:1], 1'b0};
        skmem_b_wr_req.rd_wr_en = sk_wr_stb ? power2round_pkg::RW_WRITE
                                            : power2round_pkg::RW_IDLE;
        skmem_b_wr_req.addr     = {sk_addr[power2round_pkg::MEM_ADDR_W-1:1], 1'b1};
    end

    assign rd_valid   = rd_stb;
    assign pk_wr_addr = pk_addr;

endmodule

// ==== power2round_core.sv ====
module power2round_core (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    zeroize,
    input  logic                                    rd_valid,
    input  logic [power2round_pkg::MEM_DATA_W-1:0]  mem_a_rd_data,
    input  logic [power2round_pkg::MEM_DATA_W-1:0]  mem_b_rd_data,
    output logic                                    group_valid,
    output power2round_pkg::t0_group_t              t0_group,
    output power2round_pkg::t1_group_t              t1_group
);

    logic                                       data_valid;
    logic [3:0][power2round_pkg::COEFF_W-1:0]   coeff;
    logic [3:0][power2round_pkg::COEFF_W:0]     rounded;
    power2round_pkg::t0_group_t                 t0_nxt;
    power2round_pkg::t1_group_t                 t1_nxt;

    // Port a carries coefficients 0 and 1, port b carries 2 and 3
    assign coeff = {mem_b_rd_data, mem_a_rd_data};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rounded[i] = {1'b0, coeff[i]}
                       + (power2round_pkg::COEFF_W + 1)'((1 << (power2round_pkg::MLDSA_D - 1)) - 1);
            t1_nxt.coeff[i] = rounded[i][power2round_pkg::MLDSA_D +: power2round_pkg::T1_W];
            // 4096 - t0 reduces to 4096 - t[12:0] modulo 2^13
            t0_nxt.coeff[i] = power2round_pkg::MLDSA_D'(1 << (power2round_pkg::MLDSA_D - 1))
                            - coeff[i][power2round_pkg::MLDSA_D-1:0];
        end
    end

    // Read data arrives one cycle after the strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_valid  <= 1'b0;
            group_valid <= 1'b0;
        end else if (zeroize) begin
            data_valid  <= 1'b0;
            group_valid <= 1'b0;
        end else begin
            data_valid  <= rd_valid;
            group_valid <= data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            t0_group <= t0_nxt;
            t1_group <= t1_nxt;
        end
    end

endmodule

// ==== pack_buffer.sv ====
module pack_buffer #(
    parameter type in_t  = logic [7:0],
    parameter type out_t = logic [15:0]
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic in_valid,
    input  in_t  in_data,
    output logic out_valid,
    output out_t out_data
);

    localparam int IN_W  = $bits(in_t);
    localparam int OUT_W = $bits(out_t);
    localparam int ACC_W = 2 * OUT_W;
    localparam int CNT_W = $clog2(ACC_W + 1);

    logic [ACC_W-1:0] acc, acc_shift, acc_nxt;
    logic [CNT_W-1:0] fill, fill_shift, fill_nxt;
    logic [IN_W-1:0]  in_bits;
    logic [ACC_W-1:0] in_ext;

    assign in_bits = in_data;
    assign in_ext  = {{(ACC_W - IN_W){1'b0}}, in_bits};

    // A full word sits in the low bits of the accumulator
    assign out_valid = fill >= CNT_W'(OUT_W);
    assign out_data  = out_t'(acc[OUT_W-1:0]);

    // ----------------------------------------------------------------------
    // Drop the emitted word, then append the new group above the remainder
    // ----------------------------------------------------------------------
    always_comb begin
        acc_shift  = acc;
        fill_shift = fill;
        if (out_valid) begin
            acc_shift  = acc >> OUT_W;
            fill_shift = fill - CNT_W'(OUT_W);
        end

        acc_nxt  = acc_shift;
        fill_nxt = fill_shift;
        if (in_valid) begin
            acc_nxt  = acc_shift | (in_ext << fill_shift);
            fill_nxt = fill_shift + CNT_W'(IN_W);
        end
    end

    // Bits above the fill level stay zero so the OR above is an append
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc  <= '0;
            fill <= '0;
        end else if (zeroize) begin
            acc  <= '0;
            fill <= '0;
        end else begin
            acc  <= acc_nxt;
            fill <= fill_nxt;
        end
    end

endmodule

// ==== power2round_top.sv ====
module power2round_top (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        zeroize,
    input  logic                                        enable,
    input  logic [power2round_pkg::MEM_ADDR_W-1:0]      src_base_addr,
    input  logic [power2round_pkg::MEM_ADDR_W-1:0]      sk_base_addr,
    input  logic [power2round_pkg::MEM_DATA_W-1:0]      mem_a_rd_data,
    input  logic [power2round_pkg::MEM_DATA_W-1:0]      mem_b_rd_data,
    output power2round_pkg::mem_req_t                   mem_a_rd_req,
    output power2round_pkg::mem_req_t                   mem_b_rd_req,
    output power2round_pkg::mem_req_t                   skmem_a_wr_req,
    output power2round_pkg::mem_req_t                   skmem_b_wr_req,
    output logic [power2round_pkg::SK_WORD_W/2-1:0]     skmem_a_wr_data,
    output logic [power2round_pkg::SK_WORD_W/2-1:0]     skmem_b_wr_data,
    output logic                                        pk_wren,
    output logic [power2round_pkg::PK_ADDR_W-1:0]       pk_wr_addr,
    output power2round_pkg::pk_word_t                   pk_wr_data,
    output logic                                        done
);

    logic                       rd_valid;
    logic                       group_valid;
    logic                       sk_buff_valid;
    logic                       r_valid;
    power2round_pkg::t0_group_t t0_group;
    power2round_pkg::t1_group_t t1_group;
    power2round_pkg::sk_word_t  sk_word;

    power2round_ctrl u_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .src_base_addr  (src_base_addr),
        .sk_base_addr   (sk_base_addr),
        .sk_buff_valid  (sk_buff_valid),
        .r_valid        (r_valid),
        .mem_a_rd_req   (mem_a_rd_req),
        .mem_b_rd_req   (mem_b_rd_req),
        .skmem_a_wr_req (skmem_a_wr_req),
        .skmem_b_wr_req (skmem_b_wr_req),
        .rd_valid       (rd_valid),
        .pk_wren        (pk_wren),
        .pk_wr_addr     (pk_wr_addr),
        .done           (done)
    );

    power2round_core u_core (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .rd_valid       (rd_valid),
        .mem_a_rd_data  (mem_a_rd_data),
        .mem_b_rd_data  (mem_b_rd_data),
        .group_valid    (group_valid),
        .t0_group       (t0_group),
        .t1_group       (t1_group)
    );

    // Encoded t0 into 64-bit secret-key words
    pack_buffer #(
        .in_t   (power2round_pkg::t0_group_t),
        .out_t  (power2round_pkg::sk_word_t)
    ) u_sk_buffer (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (group_valid),
        .in_data   (t0_group),
        .out_valid (sk_buff_valid),
        .out_data  (sk_word)
    );

    // t1 into 80-bit public-key words
    pack_buffer #(
        .in_t   (power2round_pkg::t1_group_t),
        .out_t  (power2round_pkg::pk_word_t)
    ) u_pk_buffer (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (group_valid),
        .in_data   (t1_group),
        .out_valid (r_valid),
        .out_data  (pk_wr_data)
    );

    assign skmem_a_wr_data = sk_word.lo;
    assign skmem_b_wr_data = sk_word.hi;

endmodule

// ==== tb_power2round.sv ====
module tb_power2round;

    localparam int CLK_PERIOD = 100;
    localparam int ADDR_W     = power2round_pkg::MEM_ADDR_W;
    localparam int DATA_W     = power2round_pkg::MEM_DATA_W;
    localparam int MEM_DEPTH  = 1 << ADDR_W;
    localparam int NUM_COEFF  = power2round_pkg::MLDSA_K * power2round_pkg::MLDSA_N;
    // Reads paced 8 per 13 cycles plus pipeline and write drain
    localparam int RUN_CYCLES  = 2 * 13 + 16;
    // Four full runs and one cut short by zeroize
    localparam int NUM_RUNS    = 5;
    localparam int TEST_CYCLES = 2 + 4 + NUM_RUNS * RUN_CYCLES + 16;

    logic                                   clk;
    logic                                   reset_n;
    logic                                   zeroize;
    logic                                   enable;
    logic [ADDR_W-1:0]                      src_base_addr;
    logic [ADDR_W-1:0]                      sk_base_addr;
    logic [DATA_W-1:0]                      mem_a_rd_data;
    logic [DATA_W-1:0]                      mem_b_rd_data;
    power2round_pkg::mem_req_t              mem_a_rd_req;
    power2round_pkg::mem_req_t              mem_b_rd_req;
    power2round_pkg::mem_req_t              skmem_a_wr_req;
    power2round_pkg::mem_req_t              skmem_b_wr_req;
    logic [31:0]                            skmem_a_wr_data;
    logic [31:0]                            skmem_b_wr_data;
    logic                                   pk_wren;
    logic [power2round_pkg::PK_ADDR_W-1:0]  pk_wr_addr;
    power2round_pkg::pk_word_t              pk_wr_data;
    logic                                   done;

    logic [DATA_W-1:0] src_mem [0:MEM_DEPTH-1];
    logic [31:0]       lfsr_state;
    int                exp_src_base;
    int                exp_sk_base;
    int                rd_count;
    int                sk_count;
    int                pk_count;
    bit                run_done;

    power2round_top dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .enable          (enable),
        .src_base_addr   (src_base_addr),
        .sk_base_addr    (sk_base_addr),
        .mem_a_rd_data   (mem_a_rd_data),
        .mem_b_rd_data   (mem_b_rd_data),
        .mem_a_rd_req    (mem_a_rd_req),
        .mem_b_rd_req    (mem_b_rd_req),
        .skmem_a_wr_req  (skmem_a_wr_req),
        .skmem_b_wr_req  (skmem_b_wr_req),
        .skmem_a_wr_data (skmem_a_wr_data),
        .skmem_b_wr_data (skmem_b_wr_data),
        .pk_wren         (pk_wren),
        .pk_wr_addr      (pk_wr_addr),
        .pk_wr_data      (pk_wr_data),
        .done            (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Source memory with one cycle read latency
    always @(posedge clk) begin
        if (mem_a_rd_req.rd_wr_en == power2round_pkg::RW_READ)
            mem_a_rd_data <= src_mem[mem_a_rd_req.addr];
        if (mem_b_rd_req.rd_wr_en == power2round_pkg::RW_READ)
            mem_b_rd_data <= src_mem[mem_b_rd_req.addr];
    end

    // ----------------------------------------------------------------------
    // Failure reporting and checks
    // ----------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [79:0] actual,
                               input logic [79:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
    endtask

    task automatic expect_idle();
        check_value("mem_a_rd_req.rd_wr_en", mem_a_rd_req.rd_wr_en, power2round_pkg::RW_IDLE);
        check_value("mem_b_rd_req.rd_wr_en", mem_b_rd_req.rd_wr_en, power2round_pkg::RW_IDLE);
        check_value("skmem_a_wr_req.rd_wr_en", skmem_a_wr_req.rd_wr_en,
                    power2round_pkg::RW_IDLE);
        check_value("skmem_b_wr_req.rd_wr_en", skmem_b_wr_req.rd_wr_en,
                    power2round_pkg::RW_IDLE);
        check_value("pk_wren", pk_wren, 1'b0);
        check_value("done", done, 1'b0);
    endtask

    // ----------------------------------------------------------------------
    // Random data
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic int random_coeff();
        int value;
        value = random_bits(23);
        if (value >= power2round_pkg::MLDSA_Q)
            value = value - power2round_pkg::MLDSA_Q;
        return value;
    endfunction

    task automatic fill_source(input int base);
        int c [0:NUM_COEFF-1];
        for (int j = 0; j < NUM_COEFF; j++)
            c[j] = random_coeff();
        // Edge values around the rounding point and the top of the range
        c[0]  = 0;
        c[9]  = 4095;
        c[22] = 4096;
        c[41] = 8191;
        c[63] = power2round_pkg::MLDSA_Q - 1;
        for (int a = 0; a < NUM_COEFF / 2; a++)
            src_mem[base + a] = {24'(c[2 * a + 1]), 24'(c[2 * a])};
    endtask

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    // Two coefficients per word with the lower one in the low half
    function automatic int coeff_at(input int j);
        logic [DATA_W-1:0] word;
        word = src_mem[exp_src_base + j / 2];
        return (j % 2) ? int'(word[47:24]) : int'(word[23:0]);
    endfunction

    // Secret-key words hold 4096 - t0 in 13 bits and public-key words hold t1 in 10 bits
    function automatic logic [79:0] expected_word(input bit pk, input int w);
        logic [79:0] word;
        int          width, field, pos, t, t1, t0, value;
        width = pk ? 80 : 64;
        field = pk ? 10 : 13;
        word  = '0;
        for (int b = 0; b < width; b++) begin
            pos     = w * width + b;
            t       = coeff_at(pos / field);
            t1      = (t + 4095) / 8192;
            t0      = t - t1 * 8192;
            value   = pk ? t1 : 4096 - t0;
            word[b] = value[pos % field];
        end
        return word;
    endfunction

    // ----------------------------------------------------------------------
    // Compare process
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        logic [79:0] exp_word;
        // All writes of a run come before its done pulse
        if (done === 1'b1) begin
            if (run_done)
                abort_run("done pulsed more than once for one run");
            check_value("read request count", rd_count, power2round_pkg::NUM_READS);
            check_value("secret-key write count", sk_count, power2round_pkg::NUM_SK_WRITES);
            check_value("public-key write count", pk_count, power2round_pkg::NUM_PK_WRITES);
            run_done = 1'b1;
        end
        if (mem_a_rd_req.rd_wr_en != power2round_pkg::RW_IDLE
                || mem_b_rd_req.rd_wr_en != power2round_pkg::RW_IDLE) begin
            if (run_done || rd_count >= power2round_pkg::NUM_READS)
                abort_run("Read request outside the address range of a run");
            check_value("mem_a_rd_req.rd_wr_en", mem_a_rd_req.rd_wr_en, power2round_pkg::RW_READ);
            check_value("mem_b_rd_req.rd_wr_en", mem_b_rd_req.rd_wr_en, power2round_pkg::RW_READ);
            check_value("mem_a_rd_req.addr", mem_a_rd_req.addr, exp_src_base + 2 * rd_count);
            check_value("mem_b_rd_req.addr", mem_b_rd_req.addr, exp_src_base + 2 * rd_count + 1);
            rd_count++;
        end
        if (skmem_a_wr_req.rd_wr_en != power2round_pkg::RW_IDLE
                || skmem_b_wr_req.rd_wr_en != power2round_pkg::RW_IDLE) begin
            if (run_done || sk_count >= power2round_pkg::NUM_SK_WRITES)
                abort_run("Secret-key write outside a run");
            exp_word = expected_word(1'b0, sk_count);
            check_value("skmem_a_wr_req.rd_wr_en", skmem_a_wr_req.rd_wr_en,
                        power2round_pkg::RW_WRITE);
            check_value("skmem_b_wr_req.rd_wr_en", skmem_b_wr_req.rd_wr_en,
                        power2round_pkg::RW_WRITE);
            check_value("skmem_a_wr_req.addr", skmem_a_wr_req.addr, exp_sk_base + 2 * sk_count);
            check_value("skmem_b_wr_req.addr", skmem_b_wr_req.addr,
                        exp_sk_base + 2 * sk_count + 1);
            check_value("skmem_a_wr_data", skmem_a_wr_data, exp_word[31:0]);
            check_value("skmem_b_wr_data", skmem_b_wr_data, exp_word[63:32]);
            sk_count++;
        end
        if (pk_wren !== 1'b0) begin
            if (run_done || pk_count >= power2round_pkg::NUM_PK_WRITES)
                abort_run("Public-key write outside a run");
            check_value("pk_wren", pk_wren, 1'b1);
            check_value("pk_wr_addr", pk_wr_addr, pk_count);
            check_value("pk_wr_data", pk_wr_data, expected_word(1'b1, pk_count));
            pk_count++;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    task automatic start_run(input int src, input int sk);
        fill_source(src);
        src_base_addr = ADDR_W'(src);
        sk_base_addr  = ADDR_W'(sk);
        exp_src_base  = src;
        exp_sk_base   = sk;
        rd_count      = 0;
        sk_count      = 0;
        pk_count      = 0;
        run_done      = 1'b0;
        enable        = 1'b1;
        @(negedge clk);
        enable        = 1'b0;
    endtask

    // Idle tail lets the compare process catch writes after done
    task automatic wait_for_done(input int tail);
        while (done !== 1'b1)
            @(negedge clk);
        repeat (tail) @(negedge clk);
    endtask

    initial begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        enable        = 1'b0;
        src_base_addr = '0;
        sk_base_addr  = '0;
        mem_a_rd_data = '0;
        mem_b_rd_data = '0;
        lfsr_state    = 32'h8888_dfda;
        exp_src_base  = 0;
        exp_sk_base   = 0;
        rd_count      = 0;
        sk_count      = 0;
        pk_count      = 0;
        run_done      = 1'b1;
        for (int a = 0; a < MEM_DEPTH; a++)
            src_mem[a] = {24'(2 * a + 1), 24'(2 * a)};
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        repeat (4) begin
            @(negedge clk);
            expect_idle();
        end

        start_run(14'h0100, 14'h0400);
        wait_for_done(4);

        // Run cut short by zeroize so the outputs fall back to idle
        start_run(14'h0240, 14'h0800);
        repeat (12) @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        run_done = 1'b1;
        expect_idle();
        repeat (2) begin
            @(negedge clk);
            expect_idle();
        end
        zeroize = 1'b0;
        repeat (3) begin
            @(negedge clk);
            expect_idle();
        end

        start_run(14'h0240, 14'h0800);
        wait_for_done(4);

        // Back-to-back runs with new bases and fresh data
        start_run(14'h1a00, 14'h2000);
        wait_for_done(2);
        start_run(14'h3fc0, 14'h0010);
        wait_for_done(4);

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(3 * TEST_CYCLES * CLK_PERIOD);
        abort_run("Timeout, the tests did not reach their end in the expected time");
    end

endmodule

// ==== sim.f ====
power2round_pkg.sv
power2round_ctrl.sv
power2round_core.sv
pack_buffer.sv
power2round_top.sv
tb_power2round.sv

// ==== Bender.yml ====
package:
  name: power2round

sources:
  - files:
      - power2round_pkg.sv
      - power2round_ctrl.sv
      - power2round_core.sv
      - pack_buffer.sv
      - power2round_top.sv
  - target: test
    files:
      - tb_power2round.sv
